// ==== all.f ====
hdl/bus_pkg.sv
hdl/scratchpad_pkg.sv
hdl/ram_model.sv
hdl/memory_arbiter.sv
hdl/scratchpad_tile_buffer.sv
hdl/memory_subsystem.sv
tests/tb_clock_gen.sv
tests/memory_arbiter_assertions.sv
tests/tb_memory_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_memory_subsystem \
  -f all.f \
  -o tb_memory_subsystem

# log is searched below, so a non-zero exit of the run is tolerated here
./obj_dir/tb_memory_subsystem > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation finished cleanly"

// ==== tests/tb_memory_subsystem.sv ====
`timescale 1ns/1ps

module tb_memory_subsystem;

  // one cache access including the idle gaps around it
  localparam int ACCESS_CYCLES = bus_pkg::RAM_LATENCY + 3;
  localparam int TILE_CYCLES = 2 * scratchpad_pkg::TILE_ROWS * (bus_pkg::RAM_LATENCY + 1) + 6;
  localparam int WORST_TEST_CYCLES = 8 * ACCESS_CYCLES + TILE_CYCLES + 4;
  localparam int NUM_TESTS = 6;
  localparam int WATCHDOG_CYCLES = 16 + NUM_TESTS * WORST_TEST_CYCLES * 4;

  logic CLK;
  logic nRST;
  bus_pkg::cache_req_t dcache_req;
  bus_pkg::cache_req_t icache_req;
  bus_pkg::cache_resp_t dcache_resp;
  bus_pkg::cache_resp_t icache_resp;
  scratchpad_pkg::sp_req_t sp_req;
  logic tile_ack;
  logic sp_store_hit;
  scratchpad_pkg::tile_t tile;
  logic tile_valid;

  integer seed;

  tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(16)) clock_gen (.CLK(CLK), .nRST(nRST));

  memory_subsystem uut (
    .CLK          (CLK),
    .nRST         (nRST),
    .dcache_req   (dcache_req),
    .icache_req   (icache_req),
    .sp_req       (sp_req),
    .tile_ack     (tile_ack),
    .dcache_resp  (dcache_resp),
    .icache_resp  (icache_resp),
    .sp_store_hit (sp_store_hit),
    .tile         (tile),
    .tile_valid   (tile_valid)
  );

  task automatic check_value(input string test, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s expected %h actual %h", test, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "%s mismatch", test);
    end
  endtask

  // holds the request until wait is seen low and done_at is that sample time
  task automatic cache_access(input bit use_dcache, input bit write, input bus_pkg::addr_t addr,
                              input bus_pkg::word_t data, output bus_pkg::word_t load,
                              output time done_at);
    bus_pkg::cache_req_t req;
    bus_pkg::cache_resp_t resp;
    req.ren = !write;
    req.wen = write;
    req.addr = addr;
    req.store = data;
    @(posedge CLK);
    #1;
    if (use_dcache) dcache_req = req;
    else icache_req = req;
    do begin
      @(negedge CLK);
      resp = use_dcache ? dcache_resp : icache_resp;
    end while (resp.mem_wait);
    load = resp.load;
    done_at = $time;
    @(posedge CLK);
    #1;
    if (use_dcache) dcache_req = '0;
    else icache_req = '0;
  endtask

  task automatic store_dword(input bus_pkg::addr_t addr, input scratchpad_pkg::dword_t data);
    @(posedge CLK);
    #1;
    sp_req.store = 1'b1;
    sp_req.store_addr = addr;
    sp_req.store_data = data;
    do begin
      @(negedge CLK);
    end while (!sp_store_hit);
    @(posedge CLK);
    #1;
    sp_req.store = 1'b0;
  endtask

  task automatic load_tile(input bus_pkg::addr_t addr, output scratchpad_pkg::tile_t got,
                           output time valid_at);
    @(posedge CLK);
    #1;
    sp_req.load = 1'b1;
    sp_req.load_addr = addr;
    do begin
      @(negedge CLK);
    end while (!tile_valid);
    valid_at = $time;
    got = tile;
    @(posedge CLK);
    #1;
    sp_req.load = 1'b0;
  endtask

  // tile stays presented until ack and is gone the cycle after
  task automatic release_tile(input string test);
    @(negedge CLK);
    check_value(test, 64'd1, 64'(tile_valid));
    @(posedge CLK);
    #1;
    tile_ack = 1'b1;
    @(posedge CLK);
    #1;
    tile_ack = 1'b0;
    @(negedge CLK);
    check_value(test, 64'd0, 64'(tile_valid));
  endtask

  task automatic test_dcache_write_read();
    bus_pkg::addr_t addr;
    bus_pkg::word_t data;
    bus_pkg::word_t load;
    time t;
    addr = $random(seed) & 32'h0000_0ffc;
    data = $random(seed);
    cache_access(1'b1, 1'b1, addr, data, load, t);
    cache_access(1'b1, 1'b0, addr, '0, load, t);
    check_value("dcache_write_read", 64'(data), 64'(load));
  endtask

  task automatic test_icache_shared();
    bus_pkg::addr_t addr;
    bus_pkg::word_t data_lo;
    bus_pkg::word_t data_hi;
    bus_pkg::word_t load;
    time t;
    addr = $random(seed) & 32'h0000_0ff8;
    data_lo = $random(seed);
    data_hi = $random(seed);
    cache_access(1'b1, 1'b1, addr, data_lo, load, t);
    cache_access(1'b1, 1'b1, addr + 32'd4, data_hi, load, t);
    cache_access(1'b0, 1'b0, addr, '0, load, t);
    check_value("icache_shared_lo", 64'(data_lo), 64'(load));
    cache_access(1'b0, 1'b0, addr + 32'd4, '0, load, t);
    check_value("icache_shared_hi", 64'(data_hi), 64'(load));
  endtask

  // icache reads the word the dcache writes in the same cycle
  task automatic test_cache_priority();
    bus_pkg::addr_t addr;
    bus_pkg::word_t data;
    bus_pkg::word_t d_load;
    bus_pkg::word_t i_load;
    time d_done;
    time i_done;
    addr = $random(seed) & 32'h0000_0ffc;
    data = $random(seed);
    fork
      cache_access(1'b1, 1'b1, addr, data, d_load, d_done);
      cache_access(1'b0, 1'b0, addr, '0, i_load, i_done);
    join
    check_value("cache_priority_order", 64'd1, 64'(d_done < i_done));
    check_value("cache_priority_data", 64'(data), 64'(i_load));
  endtask

  task automatic test_sp_store();
    bus_pkg::addr_t addr;
    scratchpad_pkg::dword_t data;
    bus_pkg::word_t load;
    time t;
    addr = $random(seed) & 32'h0000_0ff8;
    data = {$random(seed), $random(seed)};
    store_dword(addr, data);
    cache_access(1'b1, 1'b0, addr, '0, load, t);
    check_value("sp_store_lo", 64'(data[31:0]), 64'(load));
    cache_access(1'b1, 1'b0, addr + 32'd4, '0, load, t);
    check_value("sp_store_hi", 64'(data[63:32]), 64'(load));
  endtask

  task automatic test_tile_load();
    bus_pkg::addr_t base;
    bus_pkg::addr_t addr;
    bus_pkg::word_t lo [scratchpad_pkg::TILE_ROWS];
    bus_pkg::word_t hi [scratchpad_pkg::TILE_ROWS];
    bus_pkg::word_t load;
    scratchpad_pkg::tile_t got;
    scratchpad_pkg::row_idx_t row;
    time t;
    base = $random(seed) & 32'h0000_0fe0;
    addr = base;
    row = '0;
    repeat (scratchpad_pkg::TILE_ROWS) begin
      lo[row] = $random(seed);
      hi[row] = $random(seed);
      cache_access(1'b1, 1'b1, addr, lo[row], load, t);
      cache_access(1'b1, 1'b1, addr + 32'd4, hi[row], load, t);
      addr = addr + 32'd8;
      row = row + 1'b1;
    end
    load_tile(base, got, t);
    repeat (scratchpad_pkg::TILE_ROWS) begin
      check_value("tile_load_row", {hi[row], lo[row]}, got[row]);
      row = row + 1'b1;
    end
    release_tile("tile_load_valid");
  endtask

  // dcache held across a whole tile load
  task automatic test_sp_over_cache();
    bus_pkg::addr_t addr;
    bus_pkg::addr_t base;
    bus_pkg::word_t data;
    bus_pkg::word_t load;
    scratchpad_pkg::tile_t got;
    time valid_at;
    time d_done;
    addr = $random(seed) & 32'h0000_0ffc;
    data = $random(seed);
    base = $random(seed) & 32'h0000_0fe0;
    cache_access(1'b1, 1'b1, addr, data, load, d_done);
    fork
      load_tile(base, got, valid_at);
      cache_access(1'b1, 1'b0, addr, '0, load, d_done);
    join
    check_value("sp_over_cache_order", 64'd1, 64'(d_done > valid_at));
    check_value("sp_over_cache_data", 64'(data), 64'(load));
    release_tile("sp_over_cache_valid");
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("watchdog: run exceeded %0d clock cycles", WATCHDOG_CYCLES);
    $display(">>> FAIL");
    $fatal(1, "timeout");
  end

  initial begin
    seed = 32'h0cb8_2cfd;
    dcache_req = '0;
    icache_req = '0;
    sp_req = '0;
    tile_ack = 1'b0;
    wait (nRST === 1'b1);
    @(negedge CLK);
    check_value("reset_waits", 64'd3, 64'({dcache_resp.mem_wait, icache_resp.mem_wait}));
    check_value("reset_outputs", 64'd0, 64'({sp_store_hit, tile_valid}));
    test_dcache_write_read();
    test_icache_shared();
    test_cache_priority();
    test_sp_store();
    test_tile_load();
    test_sp_over_cache();
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== tests/memory_arbiter_assertions.sv ====
`timescale 1ns/1ps

module memory_arbiter_assertions (
  input logic                    CLK,
  input logic                    nRST,
  input bus_pkg::ram_req_t       ram_req,
  input bus_pkg::ram_resp_t      ram_resp,
  input bus_pkg::cache_resp_t    dcache_resp,
  input bus_pkg::cache_resp_t    icache_resp,
  input logic                    sp_store_hit,
  input scratchpad_pkg::sp_row_t sp_row
);

  // a ram access is a read or a write, never both
  ram_single_op: assert property (@(posedge CLK) disable iff (!nRST)
    !(ram_req.ren && ram_req.wen))
    else $error("ram request carries ren and wen together");

  // only the granted cache sees wait drop
  one_cache_done: assert property (@(posedge CLK) disable iff (!nRST)
    dcache_resp.mem_wait || icache_resp.mem_wait)
    else $error("both cache waits low in one cycle");

  store_hit_pulse: assert property (@(posedge CLK) disable iff (!nRST)
    sp_store_hit |=> !sp_store_hit)
    else $error("scratchpad store hit longer than one cycle");

  row_hit_pulse: assert property (@(posedge CLK) disable iff (!nRST)
    sp_row.hit |=> !sp_row.hit)
    else $error("row hit longer than one cycle");

  // ram must see the same request until busy drops
  req_stable_busy: assert property (@(posedge CLK) disable iff (!nRST)
    ram_resp.busy |=> $stable(ram_req))
    else $error("ram request changed while busy");

endmodule

bind memory_arbiter memory_arbiter_assertions arbiter_checks (
  .CLK          (CLK),
  .nRST         (nRST),
  .ram_req      (ram_req),
  .ram_resp     (ram_resp),
  .dcache_resp  (dcache_resp),
  .icache_resp  (icache_resp),
  .sp_store_hit (sp_store_hit),
  .sp_row       (sp_row)
);

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 10,
  parameter int RESET_CYCLES = 16
) (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2) CLK = ~CLK;
  end

  // release just after an edge, like every other input
  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1;
    nRST = 1'b1;
  end

endmodule

// ==== hdl/memory_subsystem.sv ====
`timescale 1ns/1ps

module memory_subsystem (
  input  logic                    CLK,
  input  logic                    nRST,
  input  bus_pkg::cache_req_t     dcache_req,
  input  bus_pkg::cache_req_t     icache_req,
  input  scratchpad_pkg::sp_req_t sp_req,
  input  logic                    tile_ack,
  output bus_pkg::cache_resp_t    dcache_resp,
  output bus_pkg::cache_resp_t    icache_resp,
  output logic                    sp_store_hit,
  output scratchpad_pkg::tile_t   tile,
  output logic                    tile_valid
);

  bus_pkg::ram_req_t ram_req;
  bus_pkg::ram_resp_t ram_resp;
  scratchpad_pkg::sp_row_t sp_row;

  memory_arbiter arbiter (
    .CLK          (CLK),
    .nRST         (nRST),
    .dcache_req   (dcache_req),
    .icache_req   (icache_req),
    .dcache_resp  (dcache_resp),
    .icache_resp  (icache_resp),
    .sp_req       (sp_req),
    .sp_store_hit (sp_store_hit),
    .sp_row       (sp_row),
    .ram_req      (ram_req),
    .ram_resp     (ram_resp)
  );

  // shared single-ported word memory
  ram_model #(
    .LATENCY (bus_pkg::RAM_LATENCY)
  ) ram (
    .CLK      (CLK),
    .nRST     (nRST),
    .ram_req  (ram_req),
    .ram_resp (ram_resp)
  );

  scratchpad_tile_buffer tile_buffer (
    .CLK        (CLK),
    .nRST       (nRST),
    .sp_row     (sp_row),
    .tile_ack   (tile_ack),
    .tile       (tile),
    .tile_valid (tile_valid)
  );

endmodule

// ==== hdl/scratchpad_tile_buffer.sv ====
`timescale 1ns/1ps

module scratchpad_tile_buffer (
  input  logic                    CLK,
  input  logic                    nRST,
  input  scratchpad_pkg::sp_row_t sp_row,
  input  logic                    tile_ack,
  output scratchpad_pkg::tile_t   tile,
  output logic                    tile_valid
);

  logic [scratchpad_pkg::TILE_ROWS-1:0] fill_mask;
  logic [scratchpad_pkg::TILE_ROWS-1:0] next_mask;
  logic [scratchpad_pkg::TILE_ROWS-1:0] row_bit;

  // slot of the incoming row
  always_comb begin
    row_bit = '0;
    if (sp_row.hit) begin
      row_bit[sp_row.row] = 1'b1;
    end
  end

  // ack empties the mask, a same-cycle row still lands
  assign next_mask = (tile_ack ? '0 : fill_mask) | row_bit;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fill_mask <= '0;
      tile_valid <= 1'b0;
    end
    else begin
      fill_mask <= next_mask;
      tile_valid <= &next_mask;
    end
  end

  // rows of a later load overwrite in place
  always_ff @(posedge CLK) begin
    if (sp_row.hit) begin
      tile[sp_row.row] <= sp_row.data;
    end
  end

endmodule

// ==== hdl/memory_arbiter.sv ====
`timescale 1ns/1ps

module memory_arbiter (
  input  logic                    CLK,
  input  logic                    nRST,
  input  bus_pkg::cache_req_t     dcache_req,
  input  bus_pkg::cache_req_t     icache_req,
  output bus_pkg::cache_resp_t    dcache_resp,
  output bus_pkg::cache_resp_t    icache_resp,
  input  scratchpad_pkg::sp_req_t sp_req,
  output logic                    sp_store_hit,
  output scratchpad_pkg::sp_row_t sp_row,
  output bus_pkg::ram_req_t       ram_req,
  input  bus_pkg::ram_resp_t      ram_resp
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_RAM,
    LOAD_LO,
    LOAD_HI,
    STORE_LO,
    STORE_HI
  } state_t;

  state_t state, next_state;

  scratchpad_pkg::row_idx_t row_cnt, next_row_cnt;
  logic grant_d, next_grant_d;
  logic load_hold, next_load_hold;

  // row sequencing strobes
  logic lo_en;
  logic row_done;

  // payload of the row in flight
  bus_pkg::word_t lo_word;
  logic row_hit;
  scratchpad_pkg::row_idx_t row_idx;
  scratchpad_pkg::dword_t row_data;

  bus_pkg::addr_t row_base;
  bus_pkg::cache_req_t granted;
  logic sp_load_go;
  logic dcache_active;
  logic icache_active;

  // cache request onto the ram bus, write wins over read
  function automatic bus_pkg::ram_req_t to_ram(input bus_pkg::cache_req_t req);
    bus_pkg::ram_req_t r;
    r.wen = req.wen;
    r.ren = req.ren && !req.wen;
    r.addr = req.addr;
    r.store = req.store;
    return r;
  endfunction

  assign row_base = sp_req.load_addr
                  + bus_pkg::addr_t'(row_cnt) * scratchpad_pkg::ROW_STRIDE;

  // a finished load must be released before the next one starts
  assign sp_load_go = sp_req.load && !load_hold;

  assign dcache_active = dcache_req.ren | dcache_req.wen;
  assign icache_active = icache_req.ren | icache_req.wen;
  assign granted = grant_d ? dcache_req : icache_req;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      row_cnt <= '0;
      grant_d <= 1'b0;
      load_hold <= 1'b0;
      row_hit <= 1'b0;
    end
    else begin
      state <= next_state;
      row_cnt <= next_row_cnt;
      grant_d <= next_grant_d;
      load_hold <= next_load_hold;
      row_hit <= row_done;
    end
  end

  always_ff @(posedge CLK) begin
    if (lo_en) begin
      lo_word <= ram_resp.load;
    end
    if (row_done) begin
      row_idx <= row_cnt;
      row_data <= {ram_resp.load, lo_word};
    end
  end

  assign sp_row.hit = row_hit;
  assign sp_row.row = row_idx;
  assign sp_row.data = row_data;

  always_comb begin
    next_state = state;
    next_row_cnt = row_cnt;
    next_grant_d = grant_d;
    next_load_hold = load_hold && sp_req.load;
    ram_req = '0;
    dcache_resp.mem_wait = 1'b1;
    icache_resp.mem_wait = 1'b1;
    dcache_resp.load = ram_resp.load;
    icache_resp.load = ram_resp.load;
    sp_store_hit = 1'b0;
    lo_en = 1'b0;
    row_done = 1'b0;
    case (state)
      IDLE: begin
        // scratchpad load, scratchpad store, dcache, icache
        if (sp_load_go) begin
          next_state = LOAD_LO;
          next_row_cnt = '0;
        end
        else if (sp_req.store) begin
          next_state = STORE_LO;
        end
        else if (dcache_active) begin
          ram_req = to_ram(dcache_req);
          next_grant_d = 1'b1;
          next_state = WAIT_RAM;
        end
        else if (icache_active) begin
          ram_req = to_ram(icache_req);
          next_grant_d = 1'b0;
          next_state = WAIT_RAM;
        end
      end
      WAIT_RAM: begin
        ram_req = to_ram(granted);
        if (!(granted.ren || granted.wen)) begin
          next_state = IDLE;
        end
        else if (!ram_resp.busy) begin
          if (grant_d) begin
            dcache_resp.mem_wait = 1'b0;
          end
          else begin
            icache_resp.mem_wait = 1'b0;
          end
          next_state = IDLE;
        end
      end
      LOAD_LO: begin
        ram_req.ren = 1'b1;
        ram_req.addr = row_base;
        if (!sp_req.load) begin
          next_state = IDLE;
        end
        else if (!ram_resp.busy) begin
          lo_en = 1'b1;
          next_state = LOAD_HI;
        end
      end
      LOAD_HI: begin
        ram_req.ren = 1'b1;
        ram_req.addr = row_base + scratchpad_pkg::HALF_STRIDE;
        if (!sp_req.load) begin
          next_state = IDLE;
        end
        else if (!ram_resp.busy) begin
          row_done = 1'b1;
          if (row_cnt == scratchpad_pkg::row_idx_t'(scratchpad_pkg::TILE_ROWS - 1)) begin
            next_load_hold = 1'b1;
            next_state = IDLE;
          end
          else begin
            next_row_cnt = row_cnt + 1'b1;
            next_state = LOAD_LO;
          end
        end
      end
      STORE_LO: begin
        ram_req.wen = 1'b1;
        ram_req.addr = sp_req.store_addr;
        ram_req.store = sp_req.store_data[31:0];
        if (!sp_req.store) begin
          next_state = IDLE;
        end
        else if (!ram_resp.busy) begin
          next_state = STORE_HI;
        end
      end
      STORE_HI: begin
        ram_req.wen = 1'b1;
        ram_req.addr = sp_req.store_addr + scratchpad_pkg::HALF_STRIDE;
        ram_req.store = sp_req.store_data[63:32];
        if (!sp_req.store) begin
          next_state = IDLE;
        end
        else if (!ram_resp.busy) begin
          sp_store_hit = 1'b1;
          next_state = IDLE;
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

endmodule

// ==== hdl/ram_model.sv ====
`timescale 1ns/1ps

module ram_model #(
  parameter int LATENCY = bus_pkg::RAM_LATENCY
) (
  input  logic              CLK,
  input  logic              nRST,
  input  bus_pkg::ram_req_t ram_req,
  output bus_pkg::ram_resp_t ram_resp
);

  // wide enough to hold LATENCY, never zero width
  localparam int CNT_W = $clog2(LATENCY + 2);

  bus_pkg::word_t mem [bus_pkg::RAM_WORDS];

  logic [CNT_W-1:0] cnt;
  logic active;
  logic ready;
  logic [bus_pkg::RAM_ADDR_BITS-1:0] idx;

  assign active = ram_req.ren | ram_req.wen;
  assign ready = (cnt == CNT_W'(LATENCY));

  // word index, byte offset dropped
  assign idx = ram_req.addr[bus_pkg::RAM_ADDR_BITS+bus_pkg::BYTE_BITS-1:bus_pkg::BYTE_BITS];

  assign ram_resp.busy = active && !ready;
  assign ram_resp.load = mem[idx];

  // counts busy cycles of a held request, restarts after the ready cycle
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cnt <= '0;
    end
    else if (!active || ready) begin
      cnt <= '0;
    end
    else begin
      cnt <= cnt + 1'b1;
    end
  end

  // write commits only in the ready cycle
  always_ff @(posedge CLK) begin
    if (ram_req.wen && ready) begin
      mem[idx] <= ram_req.store;
    end
  end

endmodule

// ==== hdl/scratchpad_pkg.sv ====
package scratchpad_pkg;

  // low word sits at the lower address
  typedef logic [63:0] dword_t;

  // tile geometry
  localparam int TILE_ROWS = 4;
  typedef logic [$clog2(TILE_ROWS)-1:0] row_idx_t;

  // byte strides inside a tile
  localparam bus_pkg::addr_t ROW_STRIDE = 32'd8;
  localparam bus_pkg::addr_t HALF_STRIDE = 32'd4;

  // held until the transfer completes
  typedef struct packed {
    logic           load;
    logic           store;
    bus_pkg::addr_t load_addr;
    bus_pkg::addr_t store_addr;
    dword_t         store_data;
  } sp_req_t;

  // one finished row, hit is a one-cycle pulse
  typedef struct packed {
    logic     hit;
    row_idx_t row;
    dword_t   data;
  } sp_row_t;

  typedef dword_t [TILE_ROWS-1:0] tile_t;

endpackage

// ==== hdl/bus_pkg.sv ====
package bus_pkg;

  // plain word and byte address
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  // ram geometry
  localparam int RAM_WORDS = 1024;
  localparam int RAM_ADDR_BITS = $clog2(RAM_WORDS);
  localparam int BYTE_BITS = 2;

  // busy cycles before each access takes effect
  localparam int RAM_LATENCY = 2;

  // request from one cache port
  typedef struct packed {
    logic  ren;
    logic  wen;
    addr_t addr;
    word_t store;
  } cache_req_t;

  // mem_wait stays high until the access is done
  typedef struct packed {
    logic  mem_wait;
    word_t load;
  } cache_resp_t;

  // arbiter to ram
  typedef struct packed {
    logic  ren;
    logic  wen;
    addr_t addr;
    word_t store;
  } ram_req_t;

  typedef struct packed {
    logic  busy;
    word_t load;
  } ram_resp_t;

endpackage
